//--- ddpRecvTop.f
source/ddpPkg.sv
source/ddpBeatFifo.sv
source/ddpCut.sv
source/recvQueueBuffer.sv
source/ddpRecvTop.sv
test/ddpRecvTb.sv

//--- Bender.yml
package:
  name: ddpRecv

sources:
  - source/ddpPkg.sv
  - source/ddpBeatFifo.sv
  - source/ddpCut.sv
  - source/recvQueueBuffer.sv
  - source/ddpRecvTop.sv
  - target: test
    files:
      - test/ddpRecvTb.sv

//--- test/ddpRecvTb.sv
`timescale 1ns/1ps

module ddpRecvTb;
   import ddpPkg::*;

   localparam int ClockPeriod = 4;
   localparam int TotalBeats = 54;
   localparam int MarginCycles = 1500;
   localparam int DrainLimit = 400;

   logic             clock;
   logic             reset;
   ddpBeat           inBeat;
   logic             inValid;
   logic             inFull;
   ddpHeader         header;
   logic             headerValid;
   logic [3:0]       readQueue;
   logic [2:0]       readIndex;
   logic [255:0]     readData;
   logic [3:0]       readCount;

   logic [31:0]      lfsrState;
   logic             sawFull;
   logic [7:0]       payloadBytes [$];
   ddpHeader         expHeaders [$];
   logic [255:0]     expWords [QueueCount][QueueDepth];
   int               expPtr [QueueCount];
   int               expCount [QueueCount];

   ddpRecvTop dut_i (
      .clock       (clock),
      .reset       (reset),
      .inBeat      (inBeat),
      .inValid     (inValid),
      .inFull      (inFull),
      .header      (header),
      .headerValid (headerValid),
      .readQueue   (readQueue),
      .readIndex   (readIndex),
      .readData    (readData),
      .readCount   (readCount)
   );

   always #(ClockPeriod / 2) clock = ~clock;

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1);
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic randomByte(output logic [7:0] b);
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsrState = lfsrNext(lfsrState);
         b = {b[6:0], lfsrState[0]};
      end
   endtask

   task automatic makePayload(input int n);
      logic [7:0] b;
      payloadBytes = {};
      for (int i = 0; i < n; i++) begin
         randomByte(b);
         payloadBytes.push_back(b);
      end
   endtask

   function automatic ddpHeader makeHeader(input ddpOpcode op, input logic [3:0] queue,
                                           input logic [7:0] tag);
      ddpHeader h;
      h.ddpControl = 8'h41;
      h.rdmapControl = {4'h4, op};
      h.queueNumber = queue;
      h.reserved = '0;
      h.rdmapHeader = {tag, 40'h00_0000_1000, 4'h0, queue};
      return h;
   endfunction

   // Expected word from payload bytes first..first+31, MSB first, zero-filled
   function automatic logic [255:0] packWord(input int first);
      logic [255:0] w;
      w = '0;
      for (int j = 0; j < 32; j++) begin
         if (first + j < payloadBytes.size()) begin
            w[255 - 8 * j -: 8] = payloadBytes[first + j];
         end
      end
      return w;
   endfunction

   task automatic modelSend(input logic [3:0] q);
      int words;
      words = (payloadBytes.size() + 31) / 32;
      for (int w = 0; w < words; w++) begin
         expWords[q][expPtr[q]] = packWord(32 * w);
         expPtr[q] = (expPtr[q] + 1) % QueueDepth;
         if (expCount[q] < QueueDepth) begin
            expCount[q]++;
         end
      end
   endtask

   // Called on a falling edge, returns on the next one
   task automatic driveBeat(input ddpBeat beat);
      while (inFull) begin
         inValid = 1'b0;
         sawFull = 1'b1;
         @(negedge clock);
      end
      inBeat = beat;
      inValid = 1'b1;
      @(negedge clock);
   endtask

   task automatic sendPacket(input ddpHeader hdr);
      logic [7:0] stream [$];
      ddpBeat     beat;
      int         total;
      int         beats;
      stream = {};
      for (int i = 0; i < HeaderBytes; i++) begin
         stream.push_back(hdr[87 - 8 * i -: 8]);
      end
      foreach (payloadBytes[i]) begin
         stream.push_back(payloadBytes[i]);
      end
      total = stream.size();
      beats = (total + 31) / 32;
      expHeaders.push_back(hdr);
      if (hdr.rdmapControl[3:0] == Send) begin
         modelSend(hdr.queueNumber);
      end
      for (int k = 0; k < beats; k++) begin
         beat.sop = k == 0;
         beat.eop = k == beats - 1;
         beat.byteCount = beat.eop ? 6'(total - 32 * k) : 6'd0;
         for (int j = 0; j < 32; j++) begin
            if (32 * k + j < total) begin
               beat.data[255 - 8 * j -: 8] = stream[32 * k + j];
            end else begin
               // Junk past byteCount that must never reach a word
               beat.data[255 - 8 * j -: 8] = 8'ha5;
            end
         end
         driveBeat(beat);
      end
   endtask

   // Headers are the done signal, then room for a flush word to land
   task automatic waitDrain();
      int cycles;
      inValid = 1'b0;
      cycles = 0;
      while (expHeaders.size() != 0 && cycles < DrainLimit) begin
         @(negedge clock);
         cycles++;
      end
      assert (expHeaders.size() == 0)
         else failRun("timed out waiting for the DUT to report all packet headers");
      repeat (4) @(negedge clock);
   endtask

   task automatic checkCount(input logic [3:0] q, input int expected);
      readQueue = q;
      readIndex = '0;
      @(negedge clock);
      assert (readCount == 4'(expected))
         else failRun($sformatf("CHECK FAILED readCount queue %0d: got 0x%h expected 0x%h",
                                q, readCount, 4'(expected)));
   endtask

   task automatic checkQueues();
      for (int q = 0; q < QueueCount; q++) begin
         checkCount(4'(q), expCount[q]);
         for (int i = 0; i < expCount[q]; i++) begin
            readIndex = 3'(i);
            @(negedge clock);
            assert (readData == expWords[q][i])
               else failRun($sformatf("CHECK FAILED readData q%0d idx%0d: got 0x%h expected 0x%h",
                                      q, i, readData, expWords[q][i]));
         end
      end
   endtask

   // Header port against the expected order
   always @(negedge clock) begin
      ddpHeader expected;
      if (reset && headerValid) begin
         assert (expHeaders.size() != 0)
            else failRun("DUT reported a header when no packet was outstanding");
         expected = expHeaders.pop_front();
         assert (header == expected)
            else failRun($sformatf("CHECK FAILED header: got 0x%h expected 0x%h",
                                   header, expected));
      end
   end

   task automatic checkIdleAfterReset();
      assert (inFull == 1'b0)
         else failRun($sformatf("CHECK FAILED inFull: got 0x%h expected 0x0", inFull));
      assert (headerValid == 1'b0)
         else failRun($sformatf("CHECK FAILED headerValid: got 0x%h expected 0x0", headerValid));
      checkQueues();
   endtask

   task automatic singleSendTwoWords();
      makePayload(64);
      sendPacket(makeHeader(Send, 4'd2, 8'h01));
      waitDrain();
      checkQueues();
   endtask

   task automatic partialWordSend();
      makePayload(45);
      sendPacket(makeHeader(Send, 4'd7, 8'h02));
      waitDrain();
      checkQueues();
   endtask

   // Header only, payload ignored
   task automatic reqAckHeaders();
      makePayload(0);
      sendPacket(makeHeader(Req, 4'd3, 8'h03));
      makePayload(30);
      sendPacket(makeHeader(Ack, 4'd4, 8'h04));
      waitDrain();
      checkQueues();
   endtask

   task automatic singleBeatSend();
      makePayload(9);
      sendPacket(makeHeader(Send, 4'd9, 8'h05));
      waitDrain();
      checkQueues();
   endtask

   task automatic backToBack();
      makePayload(40);
      sendPacket(makeHeader(Send, 4'd0, 8'h10));
      makePayload(21);
      sendPacket(makeHeader(Send, 4'd1, 8'h11));
      makePayload(100);
      sendPacket(makeHeader(Send, 4'd2, 8'h12));
      makePayload(33);
      sendPacket(makeHeader(Send, 4'd0, 8'h13));
      makePayload(5);
      sendPacket(makeHeader(Req, 4'd6, 8'h14));
      // Ten words into one queue
      makePayload(320);
      sendPacket(makeHeader(Send, 4'd5, 8'h15));
      waitDrain();
      checkCount(4'd5, QueueDepth);
      checkQueues();
   endtask

   // Every packet ends in a flush cycle, so the FIFO backs up
   task automatic fillFifo();
      sawFull = 1'b0;
      for (int i = 0; i < 12; i++) begin
         makePayload(41);
         sendPacket(makeHeader(Send, 4'(10 + i % 4), 8'(8'h20 + i)));
      end
      waitDrain();
      assert (sawFull)
         else failRun("inFull never rose while writing packets back to back");
      checkQueues();
   endtask

   initial begin
      #((TotalBeats + MarginCycles) * ClockPeriod);
      $display("watchdog expired before the tests completed");
      $display(">>> FAIL");
      $fatal(1);
   end

   initial begin
      clock = 1'b0;
      reset = 1'b0;
      inBeat = '0;
      inValid = 1'b0;
      readQueue = '0;
      readIndex = '0;
      lfsrState = 32'h165a;
      sawFull = 1'b0;
      for (int q = 0; q < QueueCount; q++) begin
         expPtr[q] = 0;
         expCount[q] = 0;
      end
      repeat (4) @(posedge clock);
      @(negedge clock);
      reset = 1'b1;
      checkIdleAfterReset();
      singleSendTwoWords();
      partialWordSend();
      reqAckHeaders();
      singleBeatSend();
      backToBack();
      fillFifo();
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- source/ddpRecvTop.sv
`timescale 1ns/1ps

module ddpRecvTop (
   input  logic             clock,
   input  logic             reset,
   input  ddpPkg::ddpBeat   inBeat,
   input  logic             inValid,
   output logic             inFull,
   output ddpPkg::ddpHeader header,
   output logic             headerValid,
   input  logic [3:0]       readQueue,
   input  logic [2:0]       readIndex,
   output logic [255:0]     readData,
   output logic [3:0]       readCount
);
   import ddpPkg::*;

   ddpBeat     headBeat;
   logic       notEmpty;
   logic       pop;
   payloadWord word;
   logic       push;

   ddpBeatFifo beatFifo_i (
      .clock     (clock),
      .reset     (reset),
      .writeBeat (inBeat),
      .write     (inValid),
      .full      (inFull),
      .headBeat  (headBeat),
      .notEmpty  (notEmpty),
      .pop       (pop)
   );

   // Header strip and payload realign
   ddpCut cut_i (
      .clock       (clock),
      .reset       (reset),
      .headBeat    (headBeat),
      .notEmpty    (notEmpty),
      .pop         (pop),
      .word        (word),
      .push        (push),
      .header      (header),
      .headerValid (headerValid)
   );

   recvQueueBuffer queueBuffer_i (
      .clock     (clock),
      .reset     (reset),
      .word      (word),
      .push      (push),
      .readQueue (readQueue),
      .readIndex (readIndex),
      .readData  (readData),
      .readCount (readCount)
   );

endmodule

//--- source/recvQueueBuffer.sv
`timescale 1ns/1ps

module recvQueueBuffer (
   input  logic               clock,
   input  logic               reset,
   input  ddpPkg::payloadWord word,
   input  logic               push,
   input  logic [3:0]         readQueue,
   input  logic [2:0]         readIndex,
   output logic [255:0]       readData,
   output logic [3:0]         readCount
);
   import ddpPkg::*;

   logic [BeatBits-1:0] memory [QueueCount][QueueDepth];
   logic [2:0]          writePointer [QueueCount];
   logic [3:0]          wordCount [QueueCount];

   // Per-queue pointers and fill levels
   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         for (int q = 0; q < QueueCount; q++) begin
            writePointer[q] <= '0;
            wordCount[q] <= '0;
         end
      end else if (push) begin
         writePointer[word.queueNumber] <= writePointer[word.queueNumber] + 3'd1;
         // Count stops at the queue depth
         if (wordCount[word.queueNumber] != 4'(QueueDepth)) begin
            wordCount[word.queueNumber] <= wordCount[word.queueNumber] + 4'd1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (push) begin
         memory[word.queueNumber][writePointer[word.queueNumber]] <= word.data;
      end
      readData <= memory[readQueue][readIndex];
   end

   assign readCount = wordCount[readQueue];

   // Oldest word of a full queue gets overwritten
   noPushWhenFull: assert property (
      @(posedge clock) disable iff (!reset)
      push |-> wordCount[word.queueNumber] != 4'(QueueDepth)
   ) else $warning("push into full queue %0d overwrites a word", word.queueNumber);

endmodule

//--- source/ddpCut.sv
`timescale 1ns/1ps

module ddpCut (
   input  logic               clock,
   input  logic               reset,
   input  ddpPkg::ddpBeat     headBeat,
   input  logic               notEmpty,
   output logic               pop,
   output ddpPkg::payloadWord word,
   output logic               push,
   output ddpPkg::ddpHeader   header,
   output logic               headerValid
);
   import ddpPkg::*;

   cutState               state;
   cutState               nextState;
   logic                  sendPacket;
   logic [4:0]            residCount;
   logic [BeatBits-1:0]   residue;

   ddpHeader              headHeader;
   logic                  isSendHead;
   logic                  sopTake;
   logic                  bodyTake;
   logic                  payloadTake;
   logic [BeatBits-1:0]   chunk;
   logic [5:0]            chunkBytes;
   logic [BeatBits-1:0]   baseData;
   logic [4:0]            baseBytes;
   logic [2*BeatBits-1:0] merged;
   logic [6:0]            totalBytes;
   logic                  wordFull;
   logic                  emitWord;
   logic [BeatBits-1:0]   emitData;

   assign headHeader = headBeat.data[BeatBits-1 -: $bits(ddpHeader)];
   assign isSendHead = headHeader.rdmapControl[3:0] == Send;

   // Idle discards stray beats, Flush leaves the FIFO alone
   assign pop = notEmpty && state != Flush;
   assign sopTake = notEmpty && state == Idle && headBeat.sop;
   assign bodyTake = notEmpty && state == Body;
   assign payloadTake = (sopTake && isSendHead) || (bodyTake && sendPacket);

   // Payload slice of the head beat, merged below the residue
   always_comb begin
      if (state == Idle) begin
         chunk = headBeat.data << (8 * HeaderBytes);
         chunkBytes = headBeat.eop ? headBeat.byteCount - 6'(HeaderBytes)
                                   : 6'(FirstPayloadBytes);
         baseData = '0;
         baseBytes = '0;
      end else begin
         chunk = headBeat.data;
         chunkBytes = headBeat.eop ? headBeat.byteCount : 6'(BeatBits / 8);
         baseData = residue;
         baseBytes = residCount;
      end
      // Zero everything below the valid bytes
      chunk = chunk & ~({BeatBits{1'b1}} >> {chunkBytes, 3'b000});
      merged = {baseData, {BeatBits{1'b0}}}
             | ({chunk, {BeatBits{1'b0}}} >> {baseBytes, 3'b000});
      totalBytes = {2'b00, baseBytes} + {1'b0, chunkBytes};
      wordFull = totalBytes >= 7'(BeatBits / 8);
   end

   always_comb begin
      nextState = state;
      emitWord = 1'b0;
      emitData = merged[2*BeatBits-1 -: BeatBits];
      case (state)
         Idle: begin
            if (sopTake && !headBeat.eop) begin
               nextState = Body;
            end
         end
         Body: begin
            if (bodyTake && headBeat.eop) begin
               // Leftover bytes past a full word need one more cycle
               if (payloadTake && wordFull && totalBytes[4:0] != 5'd0) begin
                  nextState = Flush;
               end else begin
                  nextState = Idle;
               end
            end
         end
         default: nextState = Idle;
      endcase
      if (state == Flush) begin
         emitWord = 1'b1;
         emitData = residue;
      end else if (payloadTake) begin
         emitWord = wordFull || (headBeat.eop && totalBytes != 7'd0);
      end
   end

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         state <= Idle;
         sendPacket <= 1'b0;
         residCount <= '0;
         push <= 1'b0;
         headerValid <= 1'b0;
      end else begin
         state <= nextState;
         push <= emitWord;
         headerValid <= (sopTake || bodyTake) && headBeat.eop;
         if (sopTake) begin
            sendPacket <= isSendHead;
         end
         if (payloadTake) begin
            residCount <= totalBytes[4:0];
         end
      end
   end

   always_ff @(posedge clock) begin
      if (sopTake) begin
         header <= headHeader;
      end
      if (payloadTake) begin
         residue <= wordFull ? merged[BeatBits-1:0] : merged[2*BeatBits-1 -: BeatBits];
      end
      if (emitWord) begin
         word.queueNumber <= (state == Idle) ? headHeader.queueNumber : header.queueNumber;
         word.data <= emitData;
      end
   end

   // Framing from upstream
   idleNeedsSop: assert property (
      @(posedge clock) disable iff (!reset)
      pop && state == Idle |-> headBeat.sop
   ) else $error("beat without sop consumed in Idle");

   eopByteCount: assert property (
      @(posedge clock) disable iff (!reset)
      pop && headBeat.eop |-> headBeat.byteCount inside {[6'd1:6'd32]}
   ) else $error("eop byteCount out of range");

   // Words only ever belong to the SEND header last reported
   pushOnlySend: assert property (
      @(posedge clock) disable iff (!reset)
      push |-> header.rdmapControl[3:0] == Send
   ) else $error("push for a non-SEND packet");

endmodule

//--- source/ddpBeatFifo.sv
`timescale 1ns/1ps

module ddpBeatFifo (
   input  logic           clock,
   input  logic           reset,
   input  ddpPkg::ddpBeat writeBeat,
   input  logic           write,
   output logic           full,
   output ddpPkg::ddpBeat headBeat,
   output logic           notEmpty,
   input  logic           pop
);
   import ddpPkg::*;

   ddpBeat memory [FifoDepth];

   logic [$clog2(FifoDepth)-1:0] writePointer;
   logic [$clog2(FifoDepth)-1:0] readPointer;
   logic [$clog2(FifoDepth):0]   count;
   logic                         doWrite;
   logic                         doPop;

   assign full = count == $bits(count)'(FifoDepth);
   assign notEmpty = count != '0;

   // Writes while full are lost
   assign doWrite = write && !full;
   assign doPop = pop && notEmpty;

   // Head is always visible
   assign headBeat = memory[readPointer];

   always_ff @(posedge clock or negedge reset) begin
      if (!reset) begin
         writePointer <= '0;
         readPointer <= '0;
         count <= '0;
      end else begin
         if (doWrite) begin
            writePointer <= writePointer + 1'b1;
         end
         if (doPop) begin
            readPointer <= readPointer + 1'b1;
         end
         case ({doWrite, doPop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (doWrite) begin
         memory[writePointer] <= writeBeat;
      end
   end

   // Producer must watch full
   noWriteWhenFull: assert property (
      @(posedge clock) disable iff (!reset)
      write |-> !full
   ) else $error("beat written while FIFO full, beat dropped");

   // Consumer must watch notEmpty
   noPopWhenEmpty: assert property (
      @(posedge clock) disable iff (!reset)
      pop |-> notEmpty
   ) else $error("pop while FIFO empty");

endmodule

//--- source/ddpPkg.sv
package ddpPkg;

   // Sizes
   localparam int BeatBits = 256;
   localparam int HeaderBytes = 11;
   localparam int FirstPayloadBytes = 21;
   localparam int QueueCount = 16;
   localparam int QueueDepth = 8;
   localparam int FifoDepth = 8;

   // RDMAP opcode in the low nibble of rdmapControl
   typedef enum logic [3:0] {
      Send = 4'b0011,
      Req  = 4'b0001,
      Ack  = 4'b0010
   } ddpOpcode;

   typedef enum logic [1:0] {
      Idle,
      Body,
      Flush
   } cutState;

   // One framed beat, byteCount only meaningful on eop
   typedef struct packed {
      logic                sop;
      logic                eop;
      logic [5:0]          byteCount;
      logic [BeatBits-1:0] data;
   } ddpBeat;

   // Top 88 bits of a first beat
   typedef struct packed {
      logic [7:0]  ddpControl;
      logic [7:0]  rdmapControl;
      logic [3:0]  queueNumber;
      logic [11:0] reserved;
      logic [55:0] rdmapHeader;
   } ddpHeader;

   typedef struct packed {
      logic [3:0]          queueNumber;
      logic [BeatBits-1:0] data;
   } payloadWord;

endpackage
